//--- Bender.yml
package:
  name: frame_converter

sources:
  - files:
      - hw/cscPkg.sv
      - hw/sramArbiter.sv
      - hw/yuvFetch.sv
      - hw/chromaUpsampler.sv
      - hw/colourConverter.sv
      - hw/rgbWriter.sv
      - hw/frameConverter.sv
  - target: test
    files:
      - bench/sramModel.sv
      - bench/frameConverter_tb.sv

//--- bench/frameConverter_tb.sv
`timescale 1ns/1ps

module frameConverter_tb import cscPkg::*; ();

	localparam int PairsPerRow = 8;
	localparam int RowCount = 2;
	localparam int chromaWords = PairsPerRow / 2;
	localparam int frameWords = 3 * PairsPerRow * RowCount;
	localparam int frameTimeout = 20000;

	logic Clock;
	logic Resetn;
	logic start;
	logic done;
	logic [dataWidth-1:0] sramReadData;
	logic [addrWidth-1:0] sramAddress;
	logic [dataWidth-1:0] sramWriteData;
	logic sramWriteN;

	// Plane contents as loaded, reference for model and for change checks
	logic [15:0] yPlane [RowCount * PairsPerRow];
	logic [15:0] uPlane [RowCount * chromaWords];
	logic [15:0] vPlane [RowCount * chromaWords];
	logic [15:0] firstRun [frameWords];

	int errorCount = 0;
	int checkCount = 0;
	int writeCount = 0;
	int framesStarted = 0;
	logic started = 1'b0;

	frameConverter #(
		.PairsPerRow(PairsPerRow),
		.RowCount(RowCount)
	) frameConverter_i (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.done(done),
		.sramReadData(sramReadData),
		.sramAddress(sramAddress),
		.sramWriteData(sramWriteData),
		.sramWriteN(sramWriteN)
	);

	sramModel sramModel_i (
		.Clock(Clock),
		.address(sramAddress),
		.writeData(sramWriteData),
		.writeN(sramWriteN),
		.readData(sramReadData)
	);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	// Every SRAM write strobe seen on the bus
	always @(posedge Clock) begin
		if (Resetn && !sramWriteN) begin
			writeCount <= writeCount + 1;
		end
	end

	task automatic reportError(input string message);
		$display("** Error at %0t: %s", $time, message);
		errorCount++;
	endtask

	// Quiet bus until the first start
	assert property (@(posedge Clock) disable iff (!Resetn) !started |-> !done && sramWriteN)
		else reportError("done or write strobe active before start");
	// Done rises only inside a start phase and is held while start stays high
	assert property (@(posedge Clock) disable iff (!Resetn) $rose(done) |-> start)
		else reportError("done rose without start");
	assert property (@(posedge Clock) disable iff (!Resetn) done && start |=> done)
		else reportError("done fell while start still high");
	// Return to zero one cycle after start drops
	assert property (@(posedge Clock) disable iff (!Resetn) done && !start |=> !done)
		else reportError("done not low one cycle after start fell");
	// Writes only ever land in the RGB plane
	assert property (@(posedge Clock) disable iff (!Resetn)
		!sramWriteN |-> sramAddress >= rgbBase && sramAddress < rgbBase + frameWords)
		else reportError("write outside the RGB plane");
	// Whole frame written by the time done rises
	assert property (@(posedge Clock) disable iff (!Resetn)
		$rose(done) |-> writeCount == framesStarted * frameWords)
		else reportError("write count wrong when done rose");

	function automatic int clipByte(input int value);
		if (value < 0) begin
			return 0;
		end
		if (value > 255) begin
			return 255;
		end
		return value;
	endfunction

	// Chroma sample at a row position, taps past either edge take the edge sample
	function automatic int sampleAt(input bit isV, input int row, input int index);
		int k;
		logic [15:0] word;
		k = (index < 0) ? 0 : ((index >= PairsPerRow) ? PairsPerRow - 1 : index);
		word = isV ? vPlane[row * chromaWords + k / 2] : uPlane[row * chromaWords + k / 2];
		return (k % 2 == 0) ? int'(word[15:8]) : int'(word[7:0]);
	endfunction

	// Midpoint between samples j and j+1
	function automatic int halfSample(input bit isV, input int row, input int j);
		int sum;
		sum = 21 * (sampleAt(isV, row, j - 2) + sampleAt(isV, row, j + 3))
			- 52 * (sampleAt(isV, row, j - 1) + sampleAt(isV, row, j + 2))
			+ 159 * (sampleAt(isV, row, j) + sampleAt(isV, row, j + 1));
		return clipByte((sum + 128) >>> 8);
	endfunction

	function automatic logic [23:0] pixelRgb(input int y, input int u, input int v);
		int yScaled;
		int red;
		int green;
		int blue;
		yScaled = 76284 * (y - 16);
		red = clipByte((yScaled + 104595 * (v - 128)) >>> 16);
		green = clipByte((yScaled - 25624 * (u - 128) - 53281 * (v - 128)) >>> 16);
		blue = clipByte((yScaled + 132251 * (u - 128)) >>> 16);
		return {red[7:0], green[7:0], blue[7:0]};
	endfunction

	// RGB word n of the frame, three words per pair
	function automatic logic [15:0] expectedWord(input int index);
		int pair;
		int row;
		int j;
		logic [15:0] yWord;
		logic [47:0] pixels;
		pair = index / 3;
		row = pair / PairsPerRow;
		j = pair % PairsPerRow;
		yWord = yPlane[row * PairsPerRow + j];
		pixels = {pixelRgb(yWord[15:8], sampleAt(1'b0, row, j), sampleAt(1'b1, row, j)),
			pixelRgb(yWord[7:0], halfSample(1'b0, row, j), halfSample(1'b1, row, j))};
		return pixels[47 - 16 * (index % 3) -: 16];
	endfunction

	// Row 0 random, row 1 alternating 0 and 255 to hit every clip limit
	task automatic loadPlanes();
		int row;
		int i;
		for (row = 0; row < RowCount; row++) begin
			for (i = 0; i < PairsPerRow; i++) begin
				yPlane[row * PairsPerRow + i] = (row == 1)
					? ((i % 2) ? 16'hff00 : 16'h00ff) : 16'($urandom);
			end
			for (i = 0; i < chromaWords; i++) begin
				uPlane[row * chromaWords + i] = (row == 1)
					? ((i % 2) ? 16'h00ff : 16'hff00) : 16'($urandom);
				vPlane[row * chromaWords + i] = (row == 1)
					? ((i % 2) ? 16'hff00 : 16'h00ff) : 16'($urandom);
			end
		end
		for (i = 0; i < RowCount * PairsPerRow; i++) begin
			sramModel_i.load(int'(yBase) + i, yPlane[i]);
		end
		for (i = 0; i < RowCount * chromaWords; i++) begin
			sramModel_i.load(int'(uBase) + i, uPlane[i]);
			sramModel_i.load(int'(vBase) + i, vPlane[i]);
		end
	endtask

	task automatic compareWord(input string what, input int location, input logic [15:0] expected);
		logic [15:0] got;
		got = sramModel_i.peek(location);
		checkCount++;
		assert (got === expected)
			else reportError($sformatf("%s at %0d is %h, expected %h", what, location, got, expected));
	endtask

	// RGB plane against the model, source planes untouched
	task automatic checkFrame();
		int i;
		for (i = 0; i < frameWords; i++) begin
			compareWord("RGB word", int'(rgbBase) + i, expectedWord(i));
		end
		for (i = 0; i < RowCount * PairsPerRow; i++) begin
			compareWord("Y word", int'(yBase) + i, yPlane[i]);
		end
		for (i = 0; i < RowCount * chromaWords; i++) begin
			compareWord("U word", int'(uBase) + i, uPlane[i]);
			compareWord("V word", int'(vBase) + i, vPlane[i]);
		end
	endtask

	// Sampled 1 ns after the edge so NBA updates have settled
	task automatic waitForDone(input logic level, input int limit, output bit ok);
		int cycles;
		cycles = 0;
		while (done !== level && cycles < limit) begin
			@(posedge Clock);
			#1;
			cycles++;
		end
		ok = (done === level);
		if (!ok) begin
			$display("Timeout: done did not go to %0d within %0d cycles", level, limit);
		end
	endtask

	// Full four-phase start/done cycle
	task automatic runFrame(output bit ok);
		@(posedge Clock);
		#2;
		start = 1'b1;
		started = 1'b1;
		framesStarted++;
		waitForDone(1'b1, frameTimeout, ok);
		if (ok) begin
			@(posedge Clock);
			#2;
			start = 1'b0;
			waitForDone(1'b0, 10, ok);
		end
	endtask

	initial begin
		bit ok;
		int i;
		Resetn = 1'b0;
		start = 1'b0;
		void'($urandom(28));
		repeat (5) @(posedge Clock);
		loadPlanes();
		#2;
		Resetn = 1'b1;
		// Idle stretch with start low
		repeat (10) @(posedge Clock);
		runFrame(ok);
		if (ok) begin
			checkFrame();
			// Keep the result and scramble the plane before the second run
			for (i = 0; i < frameWords; i++) begin
				firstRun[i] = sramModel_i.peek(int'(rgbBase) + i);
				sramModel_i.load(int'(rgbBase) + i, ~firstRun[i]);
			end
			runFrame(ok);
		end
		if (ok) begin
			checkFrame();
			for (i = 0; i < frameWords; i++) begin
				compareWord("repeated RGB word", int'(rgbBase) + i, firstRun[i]);
			end
			checkCount++;
			assert (writeCount == 2 * frameWords)
				else reportError($sformatf("%0d writes over two frames", writeCount));
		end
		$display("Checks: %0d  Errors: %0d  Writes: %0d", checkCount, errorCount, writeCount);
		if (ok && errorCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- bench/sramModel.sv
`timescale 1ns/1ps

module sramModel import cscPkg::*; (
	input logic Clock,
	input logic [addrWidth-1:0] address,
	input logic [dataWidth-1:0] writeData,
	input logic writeN,
	output logic [dataWidth-1:0] readData
);

	localparam int depth = 2 ** addrWidth;

	logic [dataWidth-1:0] mem [depth];
	// First read stage, data reaches readData one cycle later
	logic [dataWidth-1:0] readStage;

	// Background pattern, every address bit shows up in the word
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = 16'(i) ^ {14'h1a5c, 2'(i >> 16)};
		end
		readStage = '0;
		readData = '0;
	end

	// Write strobe is sampled on the edge that closes the grant cycle
	always @(posedge Clock) begin
		if (!writeN) begin
			mem[address] <= writeData;
		end
		// Two-cycle read pipeline
		readStage <= mem[address];
		readData <= readStage;
	end

	// Backdoor write used for preloading planes
	task automatic load(input int location, input logic [dataWidth-1:0] value);
		mem[location] = value;
	endtask

	// Backdoor read for end-of-frame comparison
	function automatic logic [dataWidth-1:0] peek(input int location);
		return mem[location];
	endfunction

endmodule

//--- hw/chromaUpsampler.sv
`timescale 1ns/1ps

module chromaUpsampler import cscPkg::*; #(
	parameter int PairsPerRow = 160
) (
	input logic Clock,
	input logic Resetn,
	input logic lumaValid,
	output logic lumaReady,
	input logic [dataWidth-1:0] luma,
	input logic chromaValid,
	output logic chromaReady,
	input chromaWord_t chroma,
	output logic yuvValid,
	input logic yuvReady,
	output yuvPair_t yuv
);

	localparam int pairWidth = $clog2(PairsPerRow);

	typedef enum logic [1:0] {Empty, Half, Full} fill_t;

	fill_t fill;
	logic [pairWidth-1:0] pairIndex;
	// Windows hold samples j-2 .. j+3 with index 0 the oldest
	logic [5:0][7:0] uWin;
	logic [5:0][7:0] vWin;
	logic [7:0] uSpare;
	logic [7:0] vSpare;
	logic [7:0] uNext;
	logic [7:0] vNext;
	logic pastEdge;
	logic needChroma;
	logic lastPair;
	logic fire;

	// Six-tap filter rounded and clipped to a byte
	function automatic logic [7:0] interpolate(input logic [5:0][7:0] win);
		logic signed [19:0] acc;
		acc = tapFar * $signed({1'b0, win[0]})
			+ tapMid * $signed({1'b0, win[1]})
			+ tapNear * $signed({1'b0, win[2]})
			+ tapNear * $signed({1'b0, win[3]})
			+ tapMid * $signed({1'b0, win[4]})
			+ tapFar * $signed({1'b0, win[5]})
			+ 20'sd128;
		acc = acc >>> 8;
		if (acc < 0) begin
			return 8'd0;
		end
		if (acc > 255) begin
			return 8'd255;
		end
		return acc[7:0];
	endfunction

	// Once the window tail passes the row end the last sample repeats
	assign pastEdge = int'(pairIndex) + 4 >= PairsPerRow;
	// Even pairs open a new chroma word and odd pairs use its low byte
	assign needChroma = !pairIndex[0] && !pastEdge;
	assign lastPair = int'(pairIndex) == PairsPerRow - 1;

	assign uNext = pastEdge ? uWin[5] : (needChroma ? chroma.u[15:8] : uSpare);
	assign vNext = pastEdge ? vWin[5] : (needChroma ? chroma.v[15:8] : vSpare);

	assign fire = (fill == Full) && lumaValid && (!needChroma || chromaValid)
		&& (!yuvValid || yuvReady);
	assign lumaReady = fire;
	// Every chroma word is taken at once while filling
	assign chromaReady = (fill != Full) || (fire && needChroma);

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			fill <= Empty;
			pairIndex <= '0;
			yuvValid <= 1'b0;
		end else begin
			if (fill != Full) begin
				if (chromaValid) begin
					fill <= (fill == Empty) ? Half : Full;
				end
			end else if (fire) begin
				if (lastPair) begin
					fill <= Empty;
					pairIndex <= '0;
				end else begin
					pairIndex <= pairIndex + 1'b1;
				end
			end
			if (fire) begin
				yuvValid <= 1'b1;
			end else if (yuvReady) begin
				yuvValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (fill == Empty && chromaValid) begin
			// Row start replicates sample 0 into the two taps before it
			uWin[3:0] <= {chroma.u[7:0], {3{chroma.u[15:8]}}};
			vWin[3:0] <= {chroma.v[7:0], {3{chroma.v[15:8]}}};
		end else if (fill == Half && chromaValid) begin
			uWin[5:4] <= {chroma.u[7:0], chroma.u[15:8]};
			vWin[5:4] <= {chroma.v[7:0], chroma.v[15:8]};
		end else if (fire) begin
			uWin <= {uNext, uWin[5:1]};
			vWin <= {vNext, vWin[5:1]};
			if (needChroma) begin
				uSpare <= chroma.u[7:0];
				vSpare <= chroma.v[7:0];
			end
			// Even chroma is the co-sited sample and odd is interpolated
			yuv <= {luma, uWin[2], interpolate(uWin), vWin[2], interpolate(vWin)};
		end
	end

	// Fetch side holds its luma word until the window takes it
	assert property (@(posedge Clock) disable iff (!Resetn)
		lumaValid && !lumaReady |=> lumaValid && $stable(luma))
		else $error("luma word changed while stalled");

	// Same rule for the chroma word
	assert property (@(posedge Clock) disable iff (!Resetn)
		chromaValid && !chromaReady |=> chromaValid && $stable(chroma))
		else $error("chroma word changed while stalled");

endmodule

//--- hw/colourConverter.sv
`timescale 1ns/1ps

module colourConverter import cscPkg::*; (
	input logic Clock,
	input logic Resetn,
	input logic yuvValid,
	output logic yuvReady,
	input yuvPair_t yuv,
	output logic rgbValid,
	input logic rgbReady,
	output rgbPair_t rgb
);

	// Offset-removed samples between the two stages
	typedef struct packed {
		logic signed [8:0] yEven;
		logic signed [8:0] yOdd;
		logic signed [8:0] uEven;
		logic signed [8:0] uOdd;
		logic signed [8:0] vEven;
		logic signed [8:0] vOdd;
	} offset_t;

	offset_t stage1;
	logic stage1Valid;
	logic stage1Load;
	logic stage2Load;
	logic [23:0] pixelEven;
	logic [23:0] pixelOdd;

	// Drop the 16 fraction bits and clip to a byte
	function automatic logic [7:0] clip(input logic signed [31:0] sum);
		logic signed [31:0] scaled;
		scaled = sum >>> 16;
		if (scaled < 0) begin
			return 8'd0;
		end
		if (scaled > 255) begin
			return 8'd255;
		end
		return scaled[7:0];
	endfunction

	// One pixel through the matrix, result packed as R, G, B
	function automatic logic [23:0] toRgb(input logic signed [8:0] y,
		input logic signed [8:0] u, input logic signed [8:0] v);
		logic signed [31:0] base;
		base = coefY * y;
		return {clip(base + coefRv * v), clip(base + coefGu * u + coefGv * v),
			clip(base + coefBu * u)};
	endfunction

	assign pixelEven = toRgb(stage1.yEven, stage1.uEven, stage1.vEven);
	assign pixelOdd = toRgb(stage1.yOdd, stage1.uOdd, stage1.vOdd);

	// Each stage moves when the one after it is empty or emptying
	assign stage2Load = !rgbValid || rgbReady;
	assign yuvReady = !stage1Valid || stage2Load;
	assign stage1Load = yuvValid && yuvReady;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			stage1Valid <= 1'b0;
			rgbValid <= 1'b0;
		end else begin
			if (stage1Load) begin
				stage1Valid <= 1'b1;
			end else if (stage2Load) begin
				stage1Valid <= 1'b0;
			end
			if (stage2Load) begin
				rgbValid <= stage1Valid;
			end
		end
	end

	always_ff @(posedge Clock) begin
		// Stage one, remove the video offsets
		if (stage1Load) begin
			stage1.yEven <= $signed({1'b0, yuv.yEven}) - 9'sd16;
			stage1.yOdd <= $signed({1'b0, yuv.yOdd}) - 9'sd16;
			stage1.uEven <= $signed({1'b0, yuv.uEven}) - 9'sd128;
			stage1.uOdd <= $signed({1'b0, yuv.uOdd}) - 9'sd128;
			stage1.vEven <= $signed({1'b0, yuv.vEven}) - 9'sd128;
			stage1.vOdd <= $signed({1'b0, yuv.vOdd}) - 9'sd128;
		end
		// Stage two, products, sums and clipping
		if (stage2Load && stage1Valid) begin
			rgb <= {pixelEven, pixelOdd};
		end
	end

endmodule

//--- hw/cscPkg.sv
package cscPkg;

	// SRAM port geometry
	localparam int addrWidth = 18;
	localparam int dataWidth = 16;

	// Cycles from address on the bus to read data back
	localparam int sramReadLatency = 2;

	// Plane start addresses in the external SRAM
	localparam logic [addrWidth-1:0] yBase = 18'd0;
	localparam logic [addrWidth-1:0] uBase = 18'd38400;
	localparam logic [addrWidth-1:0] vBase = 18'd57600;
	localparam logic [addrWidth-1:0] rgbBase = 18'd146944;

	// Six-tap chroma filter, symmetric about the two centre taps
	// Taps sum to 256 so rounding is +128 then >>> 8
	localparam logic signed [8:0] tapNear = 9'sd159;
	localparam logic signed [8:0] tapMid = -9'sd52;
	localparam logic signed [8:0] tapFar = 9'sd21;

	// Colour matrix in 16-bit fixed point
	// coefBu is above 2^17 and needs a nineteenth bit
	localparam logic signed [18:0] coefY = 19'sd76284;
	localparam logic signed [18:0] coefRv = 19'sd104595;
	localparam logic signed [18:0] coefGu = -19'sd25624;
	localparam logic signed [18:0] coefGv = -19'sd53281;
	localparam logic signed [18:0] coefBu = 19'sd132251;

	// One SRAM access as seen by the arbiter
	typedef struct packed {
		logic [addrWidth-1:0] address;
		logic [dataWidth-1:0] writeData;
		logic write;
	} memReq_t;

	// Two full-rate pixels in YUV, even sample is the earlier one
	typedef struct packed {
		logic [7:0] yEven;
		logic [7:0] yOdd;
		logic [7:0] uEven;
		logic [7:0] uOdd;
		logic [7:0] vEven;
		logic [7:0] vOdd;
	} yuvPair_t;

	// Two pixels in RGB, in the order they are packed into SRAM words
	typedef struct packed {
		logic [7:0] rEven;
		logic [7:0] gEven;
		logic [7:0] bEven;
		logic [7:0] rOdd;
		logic [7:0] gOdd;
		logic [7:0] bOdd;
	} rgbPair_t;

	// One U word and one V word, two chroma samples each
	typedef struct packed {
		logic [dataWidth-1:0] u;
		logic [dataWidth-1:0] v;
	} chromaWord_t;

endpackage

//--- hw/frameConverter.sv
`timescale 1ns/1ps

module frameConverter import cscPkg::*; #(
	parameter int PairsPerRow = 160,
	parameter int RowCount = 240
) (
	input logic Clock,
	input logic Resetn,
	input logic start,
	output logic done,
	input logic [dataWidth-1:0] sramReadData,
	output logic [addrWidth-1:0] sramAddress,
	output logic [dataWidth-1:0] sramWriteData,
	output logic sramWriteN
);

	// Arbiter side
	logic fetchReq;
	logic fetchAck;
	memReq_t fetchMem;
	logic [dataWidth-1:0] fetchData;
	logic writeReq;
	logic writeAck;
	memReq_t writeMem;

	// Pixel streams
	logic lumaValid;
	logic lumaReady;
	logic [dataWidth-1:0] luma;
	logic chromaValid;
	logic chromaReady;
	chromaWord_t chroma;
	logic yuvValid;
	logic yuvReady;
	yuvPair_t yuv;
	logic rgbValid;
	logic rgbReady;
	rgbPair_t rgb;

	yuvFetch #(
		.PairsPerRow(PairsPerRow),
		.RowCount(RowCount)
	) yuvFetch_i (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.fetchReq(fetchReq),
		.fetchMem(fetchMem),
		.fetchAck(fetchAck),
		.fetchData(fetchData),
		.lumaValid(lumaValid),
		.lumaReady(lumaReady),
		.luma(luma),
		.chromaValid(chromaValid),
		.chromaReady(chromaReady),
		.chroma(chroma)
	);

	chromaUpsampler #(
		.PairsPerRow(PairsPerRow)
	) chromaUpsampler_i (
		.Clock(Clock),
		.Resetn(Resetn),
		.lumaValid(lumaValid),
		.lumaReady(lumaReady),
		.luma(luma),
		.chromaValid(chromaValid),
		.chromaReady(chromaReady),
		.chroma(chroma),
		.yuvValid(yuvValid),
		.yuvReady(yuvReady),
		.yuv(yuv)
	);

	colourConverter colourConverter_i (
		.Clock(Clock),
		.Resetn(Resetn),
		.yuvValid(yuvValid),
		.yuvReady(yuvReady),
		.yuv(yuv),
		.rgbValid(rgbValid),
		.rgbReady(rgbReady),
		.rgb(rgb)
	);

	rgbWriter #(
		.PairsPerRow(PairsPerRow),
		.RowCount(RowCount)
	) rgbWriter_i (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.rgbValid(rgbValid),
		.rgbReady(rgbReady),
		.rgb(rgb),
		.writeReq(writeReq),
		.writeMem(writeMem),
		.writeAck(writeAck),
		.done(done)
	);

	sramArbiter sramArbiter_i (
		.Clock(Clock),
		.Resetn(Resetn),
		.fetchReq(fetchReq),
		.fetchMem(fetchMem),
		.fetchAck(fetchAck),
		.fetchData(fetchData),
		.writeReq(writeReq),
		.writeMem(writeMem),
		.writeAck(writeAck),
		.sramReadData(sramReadData),
		.sramAddress(sramAddress),
		.sramWriteData(sramWriteData),
		.sramWriteN(sramWriteN)
	);

endmodule

//--- hw/rgbWriter.sv
`timescale 1ns/1ps

module rgbWriter import cscPkg::*; #(
	parameter int PairsPerRow = 160,
	parameter int RowCount = 240
) (
	input logic Clock,
	input logic Resetn,
	input logic start,
	input logic rgbValid,
	output logic rgbReady,
	input rgbPair_t rgb,
	output logic writeReq,
	output memReq_t writeMem,
	input logic writeAck,
	output logic done
);

	localparam int framePairs = PairsPerRow * RowCount;
	localparam int frameWidth = $clog2(framePairs + 1);

	typedef enum logic [2:0] {Idle, Take, Request, Release, Finished} writeState_t;

	writeState_t state;
	rgbPair_t pair;
	logic [1:0] wordIndex;
	logic [frameWidth-1:0] pairCount;
	logic [addrWidth-1:0] address;

	// A held pair blocks the stream until its three words are out
	assign rgbReady = (state == Take);

	// Word packing, high byte first in pixel order
	always_comb begin
		writeMem.address = address;
		writeMem.write = 1'b1;
		case (wordIndex)
			2'd0: writeMem.writeData = {pair.rEven, pair.gEven};
			2'd1: writeMem.writeData = {pair.bEven, pair.rOdd};
			default: writeMem.writeData = {pair.gOdd, pair.bOdd};
		endcase
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= Idle;
			writeReq <= 1'b0;
			done <= 1'b0;
			wordIndex <= '0;
			pairCount <= '0;
			address <= '0;
		end else begin
			case (state)
				Idle: begin
					if (start) begin
						address <= rgbBase;
						pairCount <= '0;
						state <= Take;
					end
				end
				Take: begin
					if (rgbValid) begin
						wordIndex <= '0;
						writeReq <= 1'b1;
						state <= Request;
					end
				end
				Request: begin
					if (writeAck) begin
						writeReq <= 1'b0;
						state <= Release;
					end
				end
				Release: begin
					if (!writeAck) begin
						address <= address + 1'b1;
						if (wordIndex == 2'd2) begin
							pairCount <= pairCount + 1'b1;
							// Last word of the frame is acknowledged
							if (int'(pairCount) == framePairs - 1) begin
								done <= 1'b1;
								state <= Finished;
							end else begin
								state <= Take;
							end
						end else begin
							wordIndex <= wordIndex + 1'b1;
							writeReq <= 1'b1;
							state <= Request;
						end
					end
				end
				Finished: begin
					if (!start) begin
						done <= 1'b0;
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (state == Take && rgbValid) begin
			pair <= rgb;
		end
	end

endmodule

//--- hw/sramArbiter.sv
`timescale 1ns/1ps

module sramArbiter import cscPkg::*; (
	input logic Clock,
	input logic Resetn,
	input logic fetchReq,
	input memReq_t fetchMem,
	output logic fetchAck,
	output logic [dataWidth-1:0] fetchData,
	input logic writeReq,
	input memReq_t writeMem,
	output logic writeAck,
	input logic [dataWidth-1:0] sramReadData,
	output logic [addrWidth-1:0] sramAddress,
	output logic [dataWidth-1:0] sramWriteData,
	output logic sramWriteN
);

	localparam int latencyWidth = $clog2(sramReadLatency + 1);

	typedef enum logic [1:0] {Idle, WriteCycle, ReadWait, AckHold} arbState_t;

	arbState_t state;
	logic [latencyWidth-1:0] latencyCount;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= Idle;
			fetchAck <= 1'b0;
			writeAck <= 1'b0;
			latencyCount <= '0;
			sramAddress <= '0;
			sramWriteData <= '0;
			sramWriteN <= 1'b1;
		end else begin
			case (state)
				Idle: begin
					// Writer wins a tie so the pipeline keeps draining
					if (writeReq) begin
						sramAddress <= writeMem.address;
						sramWriteData <= writeMem.writeData;
						sramWriteN <= !writeMem.write;
						state <= WriteCycle;
					end else if (fetchReq) begin
						sramAddress <= fetchMem.address;
						latencyCount <= '0;
						state <= ReadWait;
					end
				end
				WriteCycle: begin
					// Strobe lasts the single grant cycle
					sramWriteN <= 1'b1;
					writeAck <= 1'b1;
					state <= AckHold;
				end
				ReadWait: begin
					// Read data lands on the last count
					if (latencyCount == latencyWidth'(sramReadLatency)) begin
						fetchAck <= 1'b1;
						state <= AckHold;
					end else begin
						latencyCount <= latencyCount + 1'b1;
					end
				end
				AckHold: begin
					// Ack falls the cycle after its req has fallen
					if (writeAck && !writeReq) begin
						writeAck <= 1'b0;
						state <= Idle;
					end
					if (fetchAck && !fetchReq) begin
						fetchAck <= 1'b0;
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Read word held for the whole ack phase
	always_ff @(posedge Clock) begin
		if (state == ReadWait && latencyCount == latencyWidth'(sramReadLatency)) begin
			fetchData <= sramReadData;
		end
	end

	// Only one requester owns the port at a time
	assert property (@(posedge Clock) disable iff (!Resetn) !(fetchAck && writeAck))
		else $error("fetch and write acknowledged together");

	// Four-phase return to zero, ack never falls ahead of its req
	assert property (@(posedge Clock) disable iff (!Resetn)
		$fell(writeAck) |-> !$past(writeReq))
		else $error("write ack dropped while write req still high");
	assert property (@(posedge Clock) disable iff (!Resetn)
		$fell(fetchAck) |-> !$past(fetchReq))
		else $error("fetch ack dropped while fetch req still high");

endmodule

//--- hw/yuvFetch.sv
`timescale 1ns/1ps

module yuvFetch import cscPkg::*; #(
	parameter int PairsPerRow = 160,
	parameter int RowCount = 240
) (
	input logic Clock,
	input logic Resetn,
	input logic start,
	output logic fetchReq,
	output memReq_t fetchMem,
	input logic fetchAck,
	input logic [dataWidth-1:0] fetchData,
	output logic lumaValid,
	input logic lumaReady,
	output logic [dataWidth-1:0] luma,
	output logic chromaValid,
	input logic chromaReady,
	output chromaWord_t chroma
);

	localparam int chromaWords = PairsPerRow / 2;
	localparam int pairWidth = $clog2(PairsPerRow + 1);
	localparam int rowWidth = $clog2(RowCount + 1);

	typedef enum logic [2:0] {Idle, Select, Request, Release, Finished} fetchState_t;
	typedef enum logic [1:0] {ReadY, ReadU, ReadV} plane_t;

	fetchState_t state;
	plane_t plane;
	logic [rowWidth-1:0] rowIndex;
	logic [pairWidth-1:0] lumaIndex;
	logic [pairWidth-1:0] chromaIndex;
	logic [dataWidth-1:0] uHold;
	logic chromaNext;
	logic lumaNext;
	logic readDone;

	// Chroma word k is first needed at pair 2k-4, so fetch it before that luma word
	assign chromaNext = (int'(chromaIndex) < chromaWords)
		&& (2 * int'(chromaIndex) <= int'(lumaIndex) + 4);
	assign lumaNext = int'(lumaIndex) < PairsPerRow;
	assign readDone = (state == Request) && fetchAck;

	// Address generation, stable while req is high
	always_comb begin
		fetchMem.write = 1'b0;
		fetchMem.writeData = '0;
		case (plane)
			ReadY: fetchMem.address = yBase
				+ addrWidth'(rowIndex) * addrWidth'(PairsPerRow) + addrWidth'(lumaIndex);
			ReadU: fetchMem.address = uBase
				+ addrWidth'(rowIndex) * addrWidth'(chromaWords) + addrWidth'(chromaIndex);
			default: fetchMem.address = vBase
				+ addrWidth'(rowIndex) * addrWidth'(chromaWords) + addrWidth'(chromaIndex);
		endcase
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= Idle;
			plane <= ReadY;
			fetchReq <= 1'b0;
			rowIndex <= '0;
			lumaIndex <= '0;
			chromaIndex <= '0;
			lumaValid <= 1'b0;
			chromaValid <= 1'b0;
		end else begin
			// Output registers fill on the final read, empty on handshake
			if (readDone && plane == ReadY) begin
				lumaValid <= 1'b1;
			end else if (lumaReady) begin
				lumaValid <= 1'b0;
			end
			if (readDone && plane == ReadV) begin
				chromaValid <= 1'b1;
			end else if (chromaReady) begin
				chromaValid <= 1'b0;
			end

			case (state)
				Idle: begin
					if (start) begin
						rowIndex <= '0;
						lumaIndex <= '0;
						chromaIndex <= '0;
						state <= Select;
					end
				end
				Select: begin
					// Wait for the target register to drain before reading
					if (chromaNext) begin
						if (!chromaValid) begin
							plane <= ReadU;
							fetchReq <= 1'b1;
							state <= Request;
						end
					end else if (lumaNext) begin
						if (!lumaValid) begin
							plane <= ReadY;
							fetchReq <= 1'b1;
							state <= Request;
						end
					end else if (int'(rowIndex) == RowCount - 1) begin
						state <= Finished;
					end else begin
						rowIndex <= rowIndex + 1'b1;
						lumaIndex <= '0;
						chromaIndex <= '0;
					end
				end
				Request: begin
					if (fetchAck) begin
						fetchReq <= 1'b0;
						if (plane == ReadY) begin
							lumaIndex <= lumaIndex + 1'b1;
						end
						if (plane == ReadV) begin
							chromaIndex <= chromaIndex + 1'b1;
						end
						state <= Release;
					end
				end
				Release: begin
					// V read follows U straight away
					if (!fetchAck) begin
						if (plane == ReadU) begin
							plane <= ReadV;
							fetchReq <= 1'b1;
							state <= Request;
						end else begin
							state <= Select;
						end
					end
				end
				Finished: begin
					if (!start) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Read data capture
	always_ff @(posedge Clock) begin
		if (readDone) begin
			case (plane)
				ReadY: luma <= fetchData;
				ReadU: uHold <= fetchData;
				default: chroma <= '{u: uHold, v: fetchData};
			endcase
		end
	end

	// Chroma words hold two samples, so a row needs an even pair count
	assert property (@(posedge Clock) (PairsPerRow % 2 == 0) && (PairsPerRow >= 6))
		else $error("PairsPerRow must be even and at least 6");

endmodule

//--- list.f
hw/cscPkg.sv
hw/sramArbiter.sv
hw/yuvFetch.sv
hw/chromaUpsampler.sv
hw/colourConverter.sv
hw/rgbWriter.sv
hw/frameConverter.sv
bench/sramModel.sv
bench/frameConverter_tb.sv
